// ==== logic/tscPkg.sv ====
`default_nettype none

package tscPkg;

	localparam int WordWidth   = 16; // datapath and instruction width
	localparam int ImmWidth    = 8; // immediate field of I-type words
	localparam int TargetWidth = 12; // jump target field of J-type words
	localparam int RegCount    = 4; // general registers in the file

	typedef logic [WordWidth-1:0]         word_t; // one data word or one instruction
	typedef logic [$clog2(RegCount)-1:0]  regIdx_t; // register number
	typedef logic [3:0]                   opcode_t; // bits 15 to 12 of the instruction
	typedef logic [5:0]                   instFunc_t; // bits 5 to 0 of an R-type word
	typedef logic [2:0]                   aluOp_t; // operation the ALU performs
	typedef logic [1:0]                   srcB_t; // where ALU operand B comes from
	typedef logic [1:0]                   branchKind_t; // which flag test decides a branch
	typedef logic [1:0]                   pcSel_t; // source of the next PC on a jump
	typedef logic [1:0]                   wbDest_t; // which field names the written register

	localparam opcode_t OpBne   = 4'd0;
	localparam opcode_t OpBeq   = 4'd1;
	localparam opcode_t OpBgz   = 4'd2;
	localparam opcode_t OpBlz   = 4'd3;
	localparam opcode_t OpAdi   = 4'd4;
	localparam opcode_t OpOri   = 4'd5;
	localparam opcode_t OpLhi   = 4'd6;
	localparam opcode_t OpLwd   = 4'd7;
	localparam opcode_t OpSwd   = 4'd8;
	localparam opcode_t OpJmp   = 4'd9;
	localparam opcode_t OpJal   = 4'd10;
	localparam opcode_t OpRtype = 4'd15; // function field selects the operation

	localparam instFunc_t FnAdd = 6'd0;
	localparam instFunc_t FnSub = 6'd1;
	localparam instFunc_t FnAnd = 6'd2;
	localparam instFunc_t FnOrr = 6'd3;
	localparam instFunc_t FnNot = 6'd4;
	localparam instFunc_t FnTcp = 6'd5;
	localparam instFunc_t FnShl = 6'd6;
	localparam instFunc_t FnShr = 6'd7;
	localparam instFunc_t FnJpr = 6'd25;
	localparam instFunc_t FnJrl = 6'd26;
	localparam instFunc_t FnWwd = 6'd28;
	localparam instFunc_t FnHlt = 6'd29;

	localparam aluOp_t AluAdd = 3'd0;
	localparam aluOp_t AluSub = 3'd1;
	localparam aluOp_t AluAnd = 3'd2;
	localparam aluOp_t AluOrr = 3'd3;
	localparam aluOp_t AluNot = 3'd4; // bitwise inverse of a
	localparam aluOp_t AluTcp = 3'd5; // two's complement of a
	localparam aluOp_t AluShl = 3'd6; // a shifted left by one
	localparam aluOp_t AluShr = 3'd7; // a shifted right by one keeping the sign

	localparam srcB_t SrcReg     = 2'd0; // register read through rt
	localparam srcB_t SrcSignImm = 2'd1;
	localparam srcB_t SrcZeroImm = 2'd2;
	localparam srcB_t SrcZero    = 2'd3; // used by BGZ and BLZ so the ALU passes rs

	localparam branchKind_t BrNe = 2'd0;
	localparam branchKind_t BrEq = 2'd1;
	localparam branchKind_t BrGz = 2'd2;
	localparam branchKind_t BrLz = 2'd3;

	localparam pcSel_t PcBranch     = 2'd0; // PC+1 or the branch target
	localparam pcSel_t PcJumpTarget = 2'd1; // upper PC bits joined with the target field
	localparam pcSel_t PcRegister   = 2'd2; // address held in rs

	localparam wbDest_t DestRt   = 2'd0;
	localparam wbDest_t DestRd   = 2'd1;
	localparam wbDest_t DestLink = 2'd2; // return address goes to the link register

	localparam regIdx_t LinkReg = 2'd2;

	typedef struct packed {
		logic        regWrite; // write the selected register at the edge
		aluOp_t      aluOp;
		srcB_t       srcB;
		branchKind_t branchKind;
		logic        isLhi; // write back the immediate in the upper byte
		logic        memRead;
		logic        memWrite;
		logic        memToReg; // write back the data memory word
		logic        isJump;
		logic        isHlt;
		logic        isWwd; // put rs on the output port
		pcSel_t      pcSel;
		logic        isBranch;
		wbDest_t     wbDest;
		logic        isLink; // write back PC+1
	} ctrl_t;

endpackage

`default_nettype wire

// ==== logic/controlUnit.sv ====
`default_nettype none

module controlUnit (
	input  logic                Clk,
	input  logic                reset_n,
	input  tscPkg::opcode_t     opCode,
	input  tscPkg::instFunc_t   instFunc,
	input  logic                halted,
	output tscPkg::ctrl_t       ctrl
);

	tscPkg::ctrl_t decoded; // raw decode before the strobes are masked
	logic          outOfReset; // high from the first edge after reset is released

	always_ff @(posedge Clk) begin
		if (!reset_n) begin
			outOfReset <= 1'b0;
		end else begin
			outOfReset <= 1'b1;
		end
	end

	always_comb begin
		decoded.regWrite   = 1'b0; // every field starts from a NOP
		decoded.aluOp      = tscPkg::AluAdd;
		decoded.srcB       = tscPkg::SrcReg;
		decoded.branchKind = tscPkg::BrNe;
		decoded.isLhi      = 1'b0;
		decoded.memRead    = 1'b0;
		decoded.memWrite   = 1'b0;
		decoded.memToReg   = 1'b0;
		decoded.isJump     = 1'b0;
		decoded.isHlt      = 1'b0;
		decoded.isWwd      = 1'b0;
		decoded.pcSel      = tscPkg::PcBranch;
		decoded.isBranch   = 1'b0;
		decoded.wbDest     = tscPkg::DestRt;
		decoded.isLink     = 1'b0;
		case (opCode)
			tscPkg::OpRtype: begin
				decoded.regWrite = 1'b1; // ALU operations write rd
				decoded.wbDest   = tscPkg::DestRd;
				case (instFunc)
					tscPkg::FnAdd: decoded.aluOp = tscPkg::AluAdd;
					tscPkg::FnSub: decoded.aluOp = tscPkg::AluSub;
					tscPkg::FnAnd: decoded.aluOp = tscPkg::AluAnd;
					tscPkg::FnOrr: decoded.aluOp = tscPkg::AluOrr;
					tscPkg::FnNot: decoded.aluOp = tscPkg::AluNot;
					tscPkg::FnTcp: decoded.aluOp = tscPkg::AluTcp;
					tscPkg::FnShl: decoded.aluOp = tscPkg::AluShl;
					tscPkg::FnShr: decoded.aluOp = tscPkg::AluShr;
					tscPkg::FnJpr: begin
						decoded.regWrite = 1'b0;
						decoded.isJump   = 1'b1;
						decoded.pcSel    = tscPkg::PcRegister;
					end
					tscPkg::FnJrl: begin
						decoded.isJump = 1'b1; // jump to rs and keep the return address
						decoded.pcSel  = tscPkg::PcRegister;
						decoded.wbDest = tscPkg::DestLink;
						decoded.isLink = 1'b1;
					end
					tscPkg::FnWwd: begin
						decoded.regWrite = 1'b0;
						decoded.isWwd    = 1'b1;
					end
					tscPkg::FnHlt: begin
						decoded.regWrite = 1'b0;
						decoded.isHlt    = 1'b1;
					end
					default: decoded.regWrite = 1'b0; // unknown function acts as a NOP
				endcase
			end
			tscPkg::OpAdi: begin
				decoded.regWrite = 1'b1;
				decoded.srcB     = tscPkg::SrcSignImm;
			end
			tscPkg::OpOri: begin
				decoded.regWrite = 1'b1;
				decoded.aluOp    = tscPkg::AluOrr;
				decoded.srcB     = tscPkg::SrcZeroImm;
			end
			tscPkg::OpLhi: begin
				decoded.regWrite = 1'b1; // value comes from the immediate path
				decoded.srcB     = tscPkg::SrcZeroImm;
				decoded.isLhi    = 1'b1;
			end
			tscPkg::OpLwd: begin
				decoded.regWrite = 1'b1; // ALU forms rs plus offset
				decoded.srcB     = tscPkg::SrcSignImm;
				decoded.memRead  = 1'b1;
				decoded.memToReg = 1'b1;
			end
			tscPkg::OpSwd: begin
				decoded.srcB     = tscPkg::SrcSignImm;
				decoded.memWrite = 1'b1;
			end
			tscPkg::OpBne, tscPkg::OpBeq, tscPkg::OpBgz, tscPkg::OpBlz: begin
				decoded.aluOp      = tscPkg::AluSub; // flags of the difference decide
				decoded.isBranch   = 1'b1;
				decoded.branchKind = tscPkg::branchKind_t'(opCode[1:0]);
				decoded.srcB       = opCode[1] ? tscPkg::SrcZero : tscPkg::SrcReg;
			end
			tscPkg::OpJmp: begin
				decoded.isJump = 1'b1;
				decoded.pcSel  = tscPkg::PcJumpTarget;
			end
			tscPkg::OpJal: begin
				decoded.regWrite = 1'b1;
				decoded.isJump   = 1'b1;
				decoded.pcSel    = tscPkg::PcJumpTarget;
				decoded.wbDest   = tscPkg::DestLink;
				decoded.isLink   = 1'b1;
			end
			default: ; // unused opcodes keep the NOP defaults
		endcase
	end

	always_comb begin
		ctrl = decoded;
		if (!reset_n || halted) begin // no state changes in reset or after HLT
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memRead  = 1'b0;
			ctrl.isWwd    = 1'b0;
		end
	end

	// a single instruction never reads and writes data memory together
	assert property (@(posedge Clk) disable iff (!outOfReset) !(ctrl.memRead && ctrl.memWrite));

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
`default_nettype none

module aluUnit (
	input  tscPkg::word_t       a,
	input  tscPkg::word_t       b,
	input  tscPkg::aluOp_t      aluOp,
	input  tscPkg::branchKind_t branchKind,
	output tscPkg::word_t       result,
	output logic                branchTaken
);

	logic zero; // result is all zeros
	logic sign; // result is negative as a signed word

	always_comb begin
		case (aluOp)
			tscPkg::AluAdd: result = a + b;
			tscPkg::AluSub: result = a - b; // also the compare for every branch
			tscPkg::AluAnd: result = a & b;
			tscPkg::AluOrr: result = a | b;
			tscPkg::AluNot: result = ~a;
			tscPkg::AluTcp: result = ~a + tscPkg::word_t'(1);
			tscPkg::AluShl: result = {a[tscPkg::WordWidth-2:0], 1'b0};
			tscPkg::AluShr: result = {a[tscPkg::WordWidth-1], a[tscPkg::WordWidth-1:1]};
			default:        result = a + b;
		endcase
	end

	assign zero = (result == '0);
	assign sign = result[tscPkg::WordWidth-1];

	// BNE and BEQ see rs minus rt, BGZ and BLZ see rs minus zero
	always_comb begin
		case (branchKind)
			tscPkg::BrNe: branchTaken = !zero;
			tscPkg::BrEq: branchTaken = zero;
			tscPkg::BrGz: branchTaken = !zero && !sign; // strictly above zero
			tscPkg::BrLz: branchTaken = sign;
			default:      branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile (
	input  logic            Clk,
	input  logic            reset_n,
	input  tscPkg::regIdx_t readA,
	input  tscPkg::regIdx_t readB,
	input  tscPkg::regIdx_t writeIdx,
	input  logic            writeEnable,
	input  tscPkg::word_t   writeData,
	output tscPkg::word_t   dataA,
	output tscPkg::word_t   dataB
);

	tscPkg::word_t regs [tscPkg::RegCount]; // the four general registers

	always_ff @(posedge Clk) begin
		if (!reset_n) begin
			for (int i = 0; i < tscPkg::RegCount; i++) begin
				regs[i] <= '0; // programs start from zeroed registers
			end
		end else if (writeEnable) begin
			regs[writeIdx] <= writeData;
		end
	end

	// reads see the old value when the same register is written this cycle
	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

`default_nettype wire

// ==== logic/pcUnit.sv ====
`default_nettype none

module pcUnit (
	input  logic                           Clk,
	input  logic                           reset_n,
	input  tscPkg::ctrl_t                  ctrl,
	input  logic                           branchTaken,
	input  tscPkg::word_t                  offset,
	input  logic [tscPkg::TargetWidth-1:0] jumpTarget,
	input  tscPkg::word_t                  regTarget,
	output tscPkg::word_t                  pc,
	output tscPkg::word_t                  pcNext1,
	output logic                           halted
);

	tscPkg::word_t nextPc; // address fetched after this instruction

	assign pcNext1 = pc + tscPkg::word_t'(1);

	always_comb begin
		nextPc = pcNext1;
		if (ctrl.isJump) begin
			case (ctrl.pcSel)
				tscPkg::PcJumpTarget: nextPc = {pc[tscPkg::WordWidth-1:tscPkg::TargetWidth], jumpTarget};
				tscPkg::PcRegister:   nextPc = regTarget; // JPR and JRL
				default:              nextPc = pcNext1;
			endcase
		end else if (ctrl.isBranch && branchTaken && ctrl.pcSel == tscPkg::PcBranch) begin
			nextPc = pcNext1 + offset; // offset counts from the following word
		end
	end

	always_ff @(posedge Clk) begin
		if (!reset_n) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			if (ctrl.isHlt) begin
				halted <= 1'b1; // stays set until the next reset
			end
			if (!halted && !ctrl.isHlt) begin
				pc <= nextPc; // PC stays on the HLT word
			end
		end
	end

	// once halted the fetch address is frozen
	assert property (@(posedge Clk) disable iff (!reset_n) halted |=> $stable(pc));

endmodule

`default_nettype wire

// ==== logic/tscCpu.sv ====
`default_nettype none

module tscCpu (
	input  logic          Clk,
	input  logic          reset_n,
	output tscPkg::word_t instAddr,
	input  tscPkg::word_t instData,
	output tscPkg::word_t dataAddr,
	input  tscPkg::word_t dataRead,
	output logic          dataWrite,
	output tscPkg::word_t writeData,
	output tscPkg::word_t outputPort,
	output logic          wwdValid,
	output logic          halted
);

	tscPkg::opcode_t                opCode;
	tscPkg::instFunc_t              instFunc;
	tscPkg::regIdx_t                rs;
	tscPkg::regIdx_t                rt;
	tscPkg::regIdx_t                rd;
	logic [tscPkg::ImmWidth-1:0]    imm;
	logic [tscPkg::TargetWidth-1:0] jumpTarget;
	tscPkg::word_t                  signImm;
	tscPkg::word_t                  zeroImm;
	tscPkg::word_t                  lhiValue; // immediate moved to the upper byte
	tscPkg::word_t                  regA; // rs contents
	tscPkg::word_t                  regB; // rt contents
	tscPkg::word_t                  operandB;
	tscPkg::word_t                  aluResult;
	tscPkg::word_t                  pcNext1;
	tscPkg::word_t                  wbData;
	tscPkg::regIdx_t                writeIdx;
	tscPkg::ctrl_t                  ctrl;
	logic                           branchTaken;

	assign opCode     = instData[15:12];
	assign rs         = instData[11:10];
	assign rt         = instData[9:8];
	assign rd         = instData[7:6];
	assign instFunc   = instData[5:0];
	assign imm        = instData[7:0]; // overlaps rd and the function field
	assign jumpTarget = instData[11:0];

	assign signImm  = {{(tscPkg::WordWidth-tscPkg::ImmWidth){imm[tscPkg::ImmWidth-1]}}, imm};
	assign zeroImm  = {{(tscPkg::WordWidth-tscPkg::ImmWidth){1'b0}}, imm};
	assign lhiValue = {imm, {(tscPkg::WordWidth-tscPkg::ImmWidth){1'b0}}};

	always_comb begin
		case (ctrl.srcB)
			tscPkg::SrcReg:     operandB = regB;
			tscPkg::SrcSignImm: operandB = signImm;
			tscPkg::SrcZeroImm: operandB = zeroImm;
			default:            operandB = '0; // BGZ and BLZ test rs alone
		endcase
	end

	always_comb begin
		case (ctrl.wbDest)
			tscPkg::DestRd:   writeIdx = rd;
			tscPkg::DestLink: writeIdx = tscPkg::LinkReg;
			default:          writeIdx = rt;
		endcase
	end

	// link beats load beats LHI beats the ALU result
	assign wbData = ctrl.isLink   ? pcNext1  :
	                ctrl.memToReg ? dataRead :
	                ctrl.isLhi    ? lhiValue : aluResult;

	assign dataAddr   = aluResult; // rs plus the sign-extended offset for LWD and SWD
	assign dataWrite  = ctrl.memWrite;
	assign writeData  = regB;
	assign outputPort = regA;
	assign wwdValid   = ctrl.isWwd;

	controlUnit u_control (.Clk(Clk), .reset_n(reset_n), .opCode(opCode), .instFunc(instFunc),
		.halted(halted), .ctrl(ctrl));

	registerFile u_regFile (.Clk(Clk), .reset_n(reset_n), .readA(rs), .readB(rt),
		.writeIdx(writeIdx), .writeEnable(ctrl.regWrite), .writeData(wbData),
		.dataA(regA), .dataB(regB));

	aluUnit u_alu (.a(regA), .b(operandB), .aluOp(ctrl.aluOp), .branchKind(ctrl.branchKind),
		.result(aluResult), .branchTaken(branchTaken));

	pcUnit u_pc (.Clk(Clk), .reset_n(reset_n), .ctrl(ctrl), .branchTaken(branchTaken),
		.offset(signImm), .jumpTarget(jumpTarget), .regTarget(regA), .pc(instAddr),
		.pcNext1(pcNext1), .halted(halted));

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
`default_nettype none

module tbClock (
	output logic Clk,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		Clk     = 1'b0;
		reset_n = 1'b0; // reset is active from time zero
		forever #4 Clk = ~Clk; // 8 ns period
	end

	initial begin
		repeat (10) @(posedge Clk);
		reset_n <= 1'b1; // released on the edge that closes the tenth cycle
	end

endmodule

`default_nettype wire

// ==== tests/tbCpu.sv ====
`default_nettype none

module tbCpu;
	timeunit 1ns;
	timeprecision 1ps;

	logic          Clk;
	logic          reset_n;
	tscPkg::word_t instAddr;
	tscPkg::word_t instData;
	tscPkg::word_t dataAddr;
	tscPkg::word_t dataRead;
	logic          dataWrite;
	tscPkg::word_t writeData;
	tscPkg::word_t outputPort;
	logic          wwdValid;
	logic          halted;

	tscPkg::word_t   instMem [256]; // program words indexed by the PC
	tscPkg::word_t   dataMem [256]; // data memory seen by the DUT
	tscPkg::word_t   modelMem [256]; // data memory of the reference model
	tscPkg::word_t   modelRegs [4];
	tscPkg::word_t   modelPc;
	logic            modelHalted;
	tscPkg::word_t   nextPc; // model state after the current instruction
	logic            nextHalted;
	logic            wbEn; // pending register write of the model
	tscPkg::regIdx_t wbIdx;
	tscPkg::word_t   wbVal;
	logic            expWrite; // expected DUT outputs for the current cycle
	tscPkg::word_t   expAddr;
	tscPkg::word_t   expWdata;
	logic            expWwd;
	tscPkg::word_t   expOut;
	int              progLength;
	int              sectionStart [6]; // first word of each tested behavior
	int              testErrors [6];
	int              curSection;
	int              reportedUpTo;
	int              checkCount;
	int              errorCount;
	int              haltedCycles;
	logic            programReady;
	logic [15:0]     lfsrState;

	tbClock u_clock (.Clk(Clk), .reset_n(reset_n));

	tscCpu u_dut (.Clk(Clk), .reset_n(reset_n), .instAddr(instAddr), .instData(instData),
		.dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite), .writeData(writeData),
		.outputPort(outputPort), .wwdValid(wwdValid), .halted(halted));

	// words past the end of the program read as HLT
	assign instData = (instAddr < progLength) ? instMem[instAddr[7:0]] :
	                  encodeR(2'd0, 2'd0, 2'd0, tscPkg::FnHlt);
	assign dataRead = dataMem[dataAddr[7:0]]; // same-cycle read

	always @(posedge Clk) begin
		if (dataWrite) begin
			dataMem[dataAddr[7:0]] <= writeData;
		end
	end

	function automatic logic [15:0] randomBits(input int count);
		logic [15:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]; // x^16+x^14+x^13+x^11+1
			lfsrState = {lfsrState[14:0], feedback};
			value     = {value[14:0], feedback}; // one step for every bit taken
		end
		return value;
	endfunction

	function automatic tscPkg::word_t encodeR(input tscPkg::regIdx_t rs, input tscPkg::regIdx_t rt,
			input tscPkg::regIdx_t rd, input tscPkg::instFunc_t fn);
		return {tscPkg::OpRtype, rs, rt, rd, fn};
	endfunction

	function automatic tscPkg::word_t encodeI(input tscPkg::opcode_t op, input tscPkg::regIdx_t rs,
			input tscPkg::regIdx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input tscPkg::word_t word);
		instMem[progLength] = word;
		progLength++;
	endtask

	// a branch skips the counter increment that follows it when taken
	task automatic emitBranch(input tscPkg::opcode_t op, input tscPkg::regIdx_t rs,
			input tscPkg::regIdx_t rt);
		emit(encodeI(op, rs, rt, 8'd1));
		emit(encodeI(tscPkg::OpAdi, 2'd2, 2'd2, 8'd1));
	endtask

	task automatic buildProgram();
		tscPkg::regIdx_t rs;
		tscPkg::regIdx_t rt;
		tscPkg::regIdx_t rd;
		int              target;
		sectionStart[1] = progLength; // ALU, immediate and LHI results
		for (int r = 0; r < 4; r++) begin
			emit(encodeI(tscPkg::OpLhi, 2'(r), 2'(r), 8'(randomBits(8))));
			emit(encodeR(2'(r), 2'd0, 2'd0, tscPkg::FnWwd));
			emit(encodeI(tscPkg::OpOri, 2'(r), 2'(r), 8'(randomBits(8))));
			emit(encodeR(2'(r), 2'd0, 2'd0, tscPkg::FnWwd));
		end
		for (int f = 0; f < 8; f++) begin
			rs = 2'(randomBits(2));
			rt = 2'(randomBits(2));
			rd = 2'(randomBits(2));
			emit(encodeR(rs, rt, rd, tscPkg::instFunc_t'(f))); // FnAdd up to FnShr
			emit(encodeR(rd, 2'd0, 2'd0, tscPkg::FnWwd));
		end
		for (int k = 0; k < 2; k++) begin
			rs = 2'(randomBits(2));
			rt = 2'(randomBits(2));
			emit(encodeI(tscPkg::OpAdi, rs, rt, 8'(randomBits(8))));
			emit(encodeR(rt, 2'd0, 2'd0, tscPkg::FnWwd));
		end
		sectionStart[2] = progLength; // store, load back into another register, show it
		for (int k = 0; k < 2; k++) begin
			rs     = 2'(randomBits(2));
			rt     = 2'(randomBits(2));
			target = randomBits(8);
			emit(encodeI(tscPkg::OpSwd, rs, rt, 8'(target)));
			emit(encodeI(tscPkg::OpLwd, rs, rt ^ 2'd1, 8'(target)));
			emit(encodeR(rt ^ 2'd1, 2'd0, 2'd0, tscPkg::FnWwd));
		end
		sectionStart[3] = progLength; // r0 = 0, r1 = 5, r3 = -3, r2 counts fall-throughs
		emit(encodeI(tscPkg::OpLhi, 2'd0, 2'd0, 8'h00));
		emit(encodeI(tscPkg::OpAdi, 2'd0, 2'd1, 8'd5));
		emit(encodeI(tscPkg::OpAdi, 2'd0, 2'd3, 8'hFD));
		emit(encodeI(tscPkg::OpLhi, 2'd0, 2'd2, 8'h00));
		emitBranch(tscPkg::OpBne, 2'd1, 2'd1); // not taken
		emitBranch(tscPkg::OpBne, 2'd1, 2'd3);
		emitBranch(tscPkg::OpBeq, 2'd1, 2'd1);
		emitBranch(tscPkg::OpBeq, 2'd1, 2'd3); // not taken
		emitBranch(tscPkg::OpBgz, 2'd1, 2'd0);
		emitBranch(tscPkg::OpBgz, 2'd3, 2'd0); // not taken
		emitBranch(tscPkg::OpBlz, 2'd3, 2'd0);
		emitBranch(tscPkg::OpBlz, 2'd1, 2'd0); // not taken
		emit(encodeR(2'd2, 2'd0, 2'd0, tscPkg::FnWwd));
		sectionStart[4] = progLength; // every jump skips exactly one word
		target = progLength + 2;
		emit({tscPkg::OpJmp, 12'(target)});
		emit(encodeI(tscPkg::OpAdi, 2'd2, 2'd2, 8'd1));
		target = progLength + 2;
		emit({tscPkg::OpJal, 12'(target)});
		emit(encodeI(tscPkg::OpAdi, 2'd2, 2'd2, 8'd1));
		emit(encodeR(2'd2, 2'd0, 2'd0, tscPkg::FnWwd)); // shows the JAL return address
		target = progLength + 3;
		emit(encodeI(tscPkg::OpAdi, 2'd0, 2'd1, 8'(target)));
		emit(encodeR(2'd1, 2'd0, 2'd0, tscPkg::FnJpr));
		emit(encodeI(tscPkg::OpAdi, 2'd2, 2'd2, 8'd1));
		target = progLength + 3;
		emit(encodeI(tscPkg::OpAdi, 2'd0, 2'd1, 8'(target)));
		emit(encodeR(2'd1, 2'd0, 2'd0, tscPkg::FnJrl));
		emit(encodeI(tscPkg::OpAdi, 2'd2, 2'd2, 8'd1));
		emit(encodeR(2'd2, 2'd0, 2'd0, tscPkg::FnWwd)); // shows the JRL return address
		sectionStart[5] = progLength;
		emit(encodeR(2'd0, 2'd0, 2'd0, tscPkg::FnHlt));
	endtask

	task automatic scheduleWrite(input tscPkg::regIdx_t idx, input tscPkg::word_t value);
		wbEn  = 1'b1;
		wbIdx = idx;
		wbVal = value;
	endtask

	// ISA rules for one instruction, from the model state before the edge
	task automatic predict();
		tscPkg::word_t inst;
		tscPkg::word_t a;
		tscPkg::word_t b;
		tscPkg::word_t sImm;
		tscPkg::word_t pc1;
		inst = (modelPc < progLength) ? instMem[modelPc[7:0]] :
		       encodeR(2'd0, 2'd0, 2'd0, tscPkg::FnHlt);
		a          = modelRegs[inst[11:10]];
		b          = modelRegs[inst[9:8]];
		sImm       = {{8{inst[7]}}, inst[7:0]};
		pc1        = modelPc + 16'd1;
		nextPc     = pc1;
		nextHalted = modelHalted;
		wbEn       = 1'b0;
		expWrite   = 1'b0;
		expAddr    = a + sImm; // effective address of LWD and SWD
		expWdata   = b;
		expWwd     = 1'b0;
		expOut     = a;
		case (inst[15:12])
			tscPkg::OpBne: if (a != b) nextPc = pc1 + sImm;
			tscPkg::OpBeq: if (a == b) nextPc = pc1 + sImm;
			tscPkg::OpBgz: if ($signed(a) > 0) nextPc = pc1 + sImm;
			tscPkg::OpBlz: if ($signed(a) < 0) nextPc = pc1 + sImm;
			tscPkg::OpAdi: scheduleWrite(inst[9:8], a + sImm);
			tscPkg::OpOri: scheduleWrite(inst[9:8], a | {8'h00, inst[7:0]});
			tscPkg::OpLhi: scheduleWrite(inst[9:8], {inst[7:0], 8'h00});
			tscPkg::OpLwd: scheduleWrite(inst[9:8], modelMem[expAddr[7:0]]);
			tscPkg::OpSwd: expWrite = 1'b1;
			tscPkg::OpJmp: nextPc = {modelPc[15:12], inst[11:0]};
			tscPkg::OpJal: begin
				nextPc = {modelPc[15:12], inst[11:0]};
				scheduleWrite(tscPkg::LinkReg, pc1);
			end
			tscPkg::OpRtype: begin
				case (inst[5:0])
					tscPkg::FnAdd: scheduleWrite(inst[7:6], a + b);
					tscPkg::FnSub: scheduleWrite(inst[7:6], a - b);
					tscPkg::FnAnd: scheduleWrite(inst[7:6], a & b);
					tscPkg::FnOrr: scheduleWrite(inst[7:6], a | b);
					tscPkg::FnNot: scheduleWrite(inst[7:6], ~a);
					tscPkg::FnTcp: scheduleWrite(inst[7:6], 16'd0 - a);
					tscPkg::FnShl: scheduleWrite(inst[7:6], a << 1);
					tscPkg::FnShr: scheduleWrite(inst[7:6], tscPkg::word_t'($signed(a) >>> 1));
					tscPkg::FnJpr: nextPc = a;
					tscPkg::FnJrl: begin
						nextPc = a;
						scheduleWrite(tscPkg::LinkReg, pc1);
					end
					tscPkg::FnWwd: expWwd = 1'b1;
					tscPkg::FnHlt: begin
						nextHalted = 1'b1;
						nextPc     = modelPc; // fetch stays on the HLT word
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		if (modelHalted) begin // a halted processor changes nothing
			nextPc   = modelPc;
			wbEn     = 1'b0;
			expWrite = 1'b0;
			expWwd   = 1'b0;
		end
	endtask

	task automatic checkValue(input string name, input tscPkg::word_t actual,
			input tscPkg::word_t expected);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			testErrors[curSection]++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	function automatic int sectionOf(input tscPkg::word_t pc);
		int k;
		k = 0;
		for (int j = 1; j < 6; j++) begin
			if (pc >= sectionStart[j]) k = j;
		end
		return k;
	endfunction

	function automatic string testName(input int k);
		case (k)
			0:       return "reset state";
			1:       return "ALU, immediate and LHI results";
			2:       return "loads and stores";
			3:       return "branches";
			4:       return "jumps and links";
			default: return "halt";
		endcase
	endfunction

	task automatic advanceReports(input int upTo);
		while (reportedUpTo < upTo) begin
			$display("Test %0d, %s: %s with %0d errors", reportedUpTo, testName(reportedUpTo),
				(testErrors[reportedUpTo] == 0) ? "pass" : "fail", testErrors[reportedUpTo]);
			reportedUpTo++;
		end
	endtask

	// outputs are stable at the falling edge, half a cycle after the inputs change
	always @(negedge Clk) begin
		if (!reset_n) begin
			curSection = 0;
			checkValue("instAddr", instAddr, '0);
			checkValue("dataWrite", tscPkg::word_t'(dataWrite), '0);
			checkValue("wwdValid", tscPkg::word_t'(wwdValid), '0);
			checkValue("halted", tscPkg::word_t'(halted), '0);
		end else if (programReady) begin
			curSection = sectionOf(modelPc);
			advanceReports(curSection); // earlier behaviors are finished by now
			predict();
			checkValue("instAddr", instAddr, modelPc);
			checkValue("halted", tscPkg::word_t'(halted), tscPkg::word_t'(modelHalted));
			checkValue("dataWrite", tscPkg::word_t'(dataWrite), tscPkg::word_t'(expWrite));
			checkValue("wwdValid", tscPkg::word_t'(wwdValid), tscPkg::word_t'(expWwd));
			if (dataWrite) begin
				checkValue("dataAddr", dataAddr, expAddr);
				checkValue("writeData", writeData, expWdata);
			end
			if (wwdValid) begin
				checkValue("outputPort", outputPort, expOut);
			end
			if (modelHalted) haltedCycles++;
			if (wbEn) modelRegs[wbIdx] = wbVal;
			if (expWrite) modelMem[expAddr[7:0]] = expWdata;
			modelPc     = nextPc;
			modelHalted = nextHalted;
		end
	end

	initial begin
		int failedTests;
		failedTests  = 0;
		lfsrState    = 16'd14; // LFSR seed
		progLength   = 0;
		curSection   = 0;
		reportedUpTo = 0;
		checkCount   = 0;
		errorCount   = 0;
		haltedCycles = 0;
		programReady = 1'b0;
		modelPc      = '0;
		modelHalted  = 1'b0;
		for (int i = 0; i < 6; i++) testErrors[i] = 0;
		for (int i = 0; i < 4; i++) modelRegs[i] = '0;
		for (int i = 0; i < 256; i++) begin
			dataMem[i]  = {8'(i) ^ 8'h5A, 8'(i)}; // every word differs from its neighbours
			modelMem[i] = {8'(i) ^ 8'h5A, 8'(i)};
		end
		buildProgram();
		programReady = 1'b1;
		wait (haltedCycles >= 6); // a few cycles to watch the halted state
		advanceReports(6);
		for (int i = 0; i < 6; i++) begin
			if (testErrors[i] != 0) failedTests++;
		end
		$display("Summary: 6 tests, %0d failed, %0d checks, %0d errors", failedTests, checkCount,
			errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		wait (programReady);
		#((progLength + 20) * 2 * 8); // twice the cycles the program and reset need
		$display("Timeout: the processor did not halt in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/tscPkg.sv
logic/controlUnit.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/pcUnit.sv
logic/tscCpu.sv
tests/tbClock.sv
tests/tbCpu.sv

// ==== Bender.yml ====
package:
  name: tsc_cpu

sources:
  - logic/tscPkg.sv
  - logic/controlUnit.sv
  - logic/aluUnit.sv
  - logic/registerFile.sv
  - logic/pcUnit.sv
  - logic/tscCpu.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/tbCpu.sv
